/* rtl/chanlog_pkg.sv */
package chanlog_pkg;

  ////////////////////
  // widths and depth

  // channel word width
  localparam int DATA_W = 32;

  // log payload is one kind bit on top of a word
  localparam int LOG_W = DATA_W + 1;

  // skid stages per channel
  localparam int LOG_PIPE_DEPTH = 4;

  ////////////////////
  // vector types

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [0:0]        log_kind_t;
  typedef logic [0:0]        src_id_t;

  // {kind, data}
  typedef logic [LOG_W-1:0]  log_payload_t;

  // record kinds
  localparam log_kind_t KIND_BEGIN = 1'b0;
  localparam log_kind_t KIND_END   = 1'b1;

  // source ids
  localparam src_id_t SRC_0 = 1'b0;
  localparam src_id_t SRC_1 = 1'b1;

  ////////////////////
  // state machines

  typedef enum logic [1:0] {LOG_IDLE, LOG_PASS, LOG_END} logger_state_t;
  typedef enum logic [1:0] {EMPTY, ONE, FULL} skid_state_t;

endpackage

/* rtl/skid_stage.sv */
`timescale 1ns/1ps

module skid_stage
  import chanlog_pkg::*;
(
  input  logic         clk,
  input  logic         rstn,
  input  logic         in_valid,
  output logic         in_ready,
  input  log_payload_t in_data,
  output logic         out_valid,
  input  logic         out_ready,
  output log_payload_t out_data
);

  skid_state_t  state;
  skid_state_t  state_n;
  log_payload_t main_q;
  log_payload_t skid_q;
  logic         ready_q;
  logic         push;
  logic         pop;

  assign push = in_valid && ready_q;
  assign pop  = out_valid && out_ready;

  assign in_ready  = ready_q;
  assign out_valid = (state != EMPTY);
  assign out_data  = main_q;

  // occupancy
  always_comb begin
    state_n = state;
    case (state)
      EMPTY: begin
        if (push) begin
          state_n = ONE;
        end
      end
      ONE: begin
        if (push && !pop) begin
          state_n = FULL;
        end else if (!push && pop) begin
          state_n = EMPTY;
        end
      end
      FULL: begin
        if (pop) begin
          state_n = ONE;
        end
      end
      default: state_n = EMPTY;
    endcase
  end

  // ready is taken from the next occupancy, so it is a flop output
  always_ff @(posedge clk) begin
    if (rstn) begin
      state   <= EMPTY;
      ready_q <= 1'b0;
    end else begin
      state   <= state_n;
      ready_q <= (state_n != FULL);
    end
  end

  // main feeds the output, skid catches the word that arrives during a stall
  always_ff @(posedge clk) begin
    if (state == FULL && pop) begin
      main_q <= skid_q;
    end else if (push && (state == EMPTY || pop)) begin
      main_q <= in_data;
    end
    if (push && state == ONE && !pop) begin
      skid_q <= in_data;
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (rstn)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

  a_no_write_full: assert property (@(posedge clk) disable iff (rstn)
    state == FULL |-> !push);

endmodule

/* rtl/skid_pipeline.sv */
`timescale 1ns/1ps

module skid_pipeline
  import chanlog_pkg::*;
(
  input  logic         clk,
  input  logic         rstn,
  input  logic         in_valid,
  output logic         in_ready,
  input  log_payload_t in_data,
  output logic         out_valid,
  input  logic         out_ready,
  output log_payload_t out_data
);

  // link i feeds stage i, link i+1 is its output
  logic         link_valid [0:LOG_PIPE_DEPTH];
  logic         link_ready [0:LOG_PIPE_DEPTH];
  log_payload_t link_data  [0:LOG_PIPE_DEPTH];

  // head of the chain
  assign link_valid[0] = in_valid;
  assign link_data[0]  = in_data;
  assign in_ready      = link_ready[0];

  // tail of the chain
  assign out_valid                  = link_valid[LOG_PIPE_DEPTH];
  assign out_data                   = link_data[LOG_PIPE_DEPTH];
  assign link_ready[LOG_PIPE_DEPTH] = out_ready;

  ////////////////////
  // stages

  for (genvar i = 0; i < LOG_PIPE_DEPTH; i++) begin : g_stage
    skid_stage i_skid_stage (
      .clk       (clk),
      .rstn      (rstn),
      .in_valid  (link_valid[i]),
      .in_ready  (link_ready[i]),
      .in_data   (link_data[i]),
      .out_valid (link_valid[i+1]),
      .out_ready (link_ready[i+1]),
      .out_data  (link_data[i+1])
    );
  end

endmodule

/* rtl/handshake_logger.sv */
`timescale 1ns/1ps

module handshake_logger
  import chanlog_pkg::*;
(
  input  logic         clk,
  input  logic         rstn,
  input  logic         in_valid,
  output logic         in_ready,
  input  data_t        in_data,
  output logic         out_valid,
  input  logic         out_ready,
  output data_t        out_data,
  output logic         log_valid,
  input  logic         log_ready,
  output log_payload_t log_data
);

  logger_state_t state;
  logger_state_t state_n;
  data_t         wait_cnt;
  logic          log_fire;
  logic          out_fire;
  logic          out_stall;

  ////////////////////
  // channel side

  // the channel only moves once its begin record is out
  assign in_ready  = (state == LOG_PASS) && out_ready;
  assign out_valid = (state == LOG_PASS) && in_valid;
  assign out_data  = in_data;

  assign out_fire  = out_valid && out_ready;
  assign out_stall = out_valid && !out_ready;

  ////////////////////
  // log side

  // begin record is offered straight from the held input word
  assign log_valid = (state == LOG_END) || (state == LOG_IDLE && in_valid);
  assign log_data  = (state == LOG_END) ? {KIND_END, wait_cnt}
                                        : {KIND_BEGIN, in_data};
  assign log_fire  = log_valid && log_ready;

  always_comb begin
    state_n = state;
    case (state)
      LOG_IDLE: begin
        if (log_fire) begin
          state_n = LOG_PASS;
        end
      end
      LOG_PASS: begin
        if (out_fire) begin
          state_n = LOG_END;
        end
      end
      LOG_END: begin
        if (log_fire) begin
          state_n = LOG_IDLE;
        end
      end
      default: state_n = LOG_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      state <= LOG_IDLE;
    end else begin
      state <= state_n;
    end
  end

  // stall cycles of the current transfer
  always_ff @(posedge clk) begin
    if (rstn) begin
      wait_cnt <= '0;
    end else if (state == LOG_IDLE && log_fire) begin
      wait_cnt <= '0;
    end else if (out_stall) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  a_out_only_pass: assert property (@(posedge clk) disable iff (rstn)
    out_valid |-> state == LOG_PASS);

  a_log_outside_pass: assert property (@(posedge clk) disable iff (rstn)
    log_valid |-> state != LOG_PASS);

  // a waiting record must not change under the pipeline
  a_log_hold: assert property (@(posedge clk) disable iff (rstn)
    log_valid && !log_ready |=> log_valid && $stable(log_data));

endmodule

/* rtl/log_arbiter.sv */
`timescale 1ns/1ps

module log_arbiter
  import chanlog_pkg::*;
(
  input  logic         clk,
  input  logic         rstn,
  input  logic         req0_valid,
  input  logic         req1_valid,
  output logic         req0_ready,
  output logic         req1_ready,
  input  log_payload_t req0_data,
  input  log_payload_t req1_data,
  output logic         log_valid,
  input  logic         log_ready,
  output src_id_t      log_src,
  output log_kind_t    log_kind,
  output data_t        log_data
);

  // priority pointer, moves only after a transfer
  src_id_t      grant_q;
  // source of a record left waiting on the bus
  src_id_t      held_q;
  logic         lock_q;
  src_id_t      grant;
  logic [1:0]   req_valid;
  log_payload_t sel_data;

  assign req_valid = {req1_valid, req0_valid};

  // favoured source first, the other one if it is idle
  always_comb begin
    if (lock_q) begin
      grant = held_q;
    end else if (req_valid[grant_q]) begin
      grant = grant_q;
    end else if (req_valid[~grant_q]) begin
      grant = ~grant_q;
    end else begin
      grant = grant_q;
    end
  end

  ////////////////////
  // bus mux

  assign sel_data   = (grant == SRC_1) ? req1_data : req0_data;
  assign log_valid  = req_valid[grant];
  assign log_src    = grant;
  assign log_kind   = sel_data[DATA_W];
  assign log_data   = sel_data[DATA_W-1:0];

  assign req0_ready = log_ready && (grant == SRC_0);
  assign req1_ready = log_ready && (grant == SRC_1);

  always_ff @(posedge clk) begin
    if (rstn) begin
      grant_q <= SRC_0;
      held_q  <= SRC_0;
      lock_q  <= 1'b0;
    end else begin
      held_q <= grant;
      if (log_valid && log_ready) begin
        // the other source goes first next time
        grant_q <= ~grant;
        lock_q  <= 1'b0;
      end else if (log_valid) begin
        lock_q <= 1'b1;
      end
    end
  end

  a_grant_hold: assert property (@(posedge clk) disable iff (rstn)
    log_valid && !log_ready |=> grant == $past(grant));

endmodule

/* rtl/chanlog_top.sv */
`timescale 1ns/1ps

module chanlog_top
  import chanlog_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      ch_0_in_valid,
  output logic      ch_0_in_ready,
  input  data_t     ch_0_in_data,
  output logic      ch_0_out_valid,
  input  logic      ch_0_out_ready,
  output data_t     ch_0_out_data,
  input  logic      ch_1_in_valid,
  output logic      ch_1_in_ready,
  input  data_t     ch_1_in_data,
  output logic      ch_1_out_valid,
  input  logic      ch_1_out_ready,
  output data_t     ch_1_out_data,
  output logic      log_valid,
  input  logic      log_ready,
  output src_id_t   log_src,
  output log_kind_t log_kind,
  output data_t     log_data
);

  // logger to pipeline
  logic         lg0_valid;
  logic         lg0_ready;
  log_payload_t lg0_data;
  logic         lg1_valid;
  logic         lg1_ready;
  log_payload_t lg1_data;

  // pipeline to arbiter
  logic         pp0_valid;
  logic         pp0_ready;
  log_payload_t pp0_data;
  logic         pp1_valid;
  logic         pp1_ready;
  log_payload_t pp1_data;

  ////////////////////
  // channel 0

  handshake_logger i_logger_0 (
    .clk       (clk),            .rstn      (rstn),
    .in_valid  (ch_0_in_valid),  .in_ready  (ch_0_in_ready),  .in_data  (ch_0_in_data),
    .out_valid (ch_0_out_valid), .out_ready (ch_0_out_ready), .out_data (ch_0_out_data),
    .log_valid (lg0_valid),      .log_ready (lg0_ready),      .log_data (lg0_data)
  );

  skid_pipeline i_pipe_0 (
    .clk       (clk),       .rstn      (rstn),
    .in_valid  (lg0_valid), .in_ready  (lg0_ready), .in_data  (lg0_data),
    .out_valid (pp0_valid), .out_ready (pp0_ready), .out_data (pp0_data)
  );

  ////////////////////
  // channel 1

  handshake_logger i_logger_1 (
    .clk       (clk),            .rstn      (rstn),
    .in_valid  (ch_1_in_valid),  .in_ready  (ch_1_in_ready),  .in_data  (ch_1_in_data),
    .out_valid (ch_1_out_valid), .out_ready (ch_1_out_ready), .out_data (ch_1_out_data),
    .log_valid (lg1_valid),      .log_ready (lg1_ready),      .log_data (lg1_data)
  );

  skid_pipeline i_pipe_1 (
    .clk       (clk),       .rstn      (rstn),
    .in_valid  (lg1_valid), .in_ready  (lg1_ready), .in_data  (lg1_data),
    .out_valid (pp1_valid), .out_ready (pp1_ready), .out_data (pp1_data)
  );

  ////////////////////
  // shared log bus

  log_arbiter i_arbiter (
    .clk        (clk),       .rstn       (rstn),
    .req0_valid (pp0_valid), .req1_valid (pp1_valid),
    .req0_ready (pp0_ready), .req1_ready (pp1_ready),
    .req0_data  (pp0_data),  .req1_data  (pp1_data),
    .log_valid  (log_valid), .log_ready  (log_ready),
    .log_src    (log_src),   .log_kind   (log_kind),  .log_data (log_data)
  );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rstn
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // rstn is the active high reset, held for 5 cycles
  initial begin
    rstn = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstn = 1'b0;
  end

endmodule

/* tests/tb_chanlog.sv */
`timescale 1ns/1ps

module tb_chanlog
  import chanlog_pkg::*;
();

  // one stimulus row
  typedef struct packed {
    logic [1:0] active;
    logic [7:0] words;
    data_t      first;
    logic [7:0] out_stall;
    logic [7:0] log_stall;
  } row_t;

  logic       clk;
  logic       rstn;
  logic [1:0] in_valid;
  logic [1:0] in_ready;
  data_t      in_data [2];
  logic [1:0] out_valid;
  logic [1:0] out_ready;
  data_t      out_data [2];
  logic       log_valid;
  logic       log_ready;
  src_id_t    log_src;
  log_kind_t  log_kind;
  data_t      log_data;

  // reference model queues
  data_t        exp_out [2][$];
  log_payload_t exp_log [2][$];
  data_t        stall_cnt [2];
  int           rec_count [2];

  // last bus record left waiting
  logic         held_valid;
  src_id_t      held_src;
  log_kind_t    held_kind;
  data_t        held_data;

  integer seed = 13;
  int     out_stall_pct;
  int     log_stall_pct;
  int     error_count;
  int     check_count;

  ////////////////////
  // stimulus table

  // channels, words, first word, out stall %, log stall %
  row_t test_table [7] = '{
    '{2'b01, 8'd16, 32'h0000_1000, 8'd0,  8'd0},
    '{2'b10, 8'd16, 32'h0000_2000, 8'd0,  8'd0},
    '{2'b11, 8'd16, 32'hA5A5_0000, 8'd0,  8'd0},
    '{2'b01, 8'd24, 32'h1234_5600, 8'd50, 8'd0},
    '{2'b11, 8'd24, 32'hCAFE_0000, 8'd40, 8'd0},
    '{2'b11, 8'd32, 32'h8000_0000, 8'd0,  8'd60},
    '{2'b11, 8'd32, 32'hFFFF_FF00, 8'd50, 8'd50}
  };

  tb_clock i_tb_clock (
    .clk  (clk),
    .rstn (rstn)
  );

  chanlog_top i_chanlog_top (
    .clk            (clk),
    .rstn           (rstn),
    .ch_0_in_valid  (in_valid[0]),
    .ch_0_in_ready  (in_ready[0]),
    .ch_0_in_data   (in_data[0]),
    .ch_0_out_valid (out_valid[0]),
    .ch_0_out_ready (out_ready[0]),
    .ch_0_out_data  (out_data[0]),
    .ch_1_in_valid  (in_valid[1]),
    .ch_1_in_ready  (in_ready[1]),
    .ch_1_in_data   (in_data[1]),
    .ch_1_out_valid (out_valid[1]),
    .ch_1_out_ready (out_ready[1]),
    .ch_1_out_data  (out_data[1]),
    .log_valid      (log_valid),
    .log_ready      (log_ready),
    .log_src        (log_src),
    .log_kind       (log_kind),
    .log_data       (log_data)
  );

  ////////////////////
  // compare tasks

  task automatic check_data(input string name, input data_t got, input data_t exp);
    check_count++;
    if (got !== exp) begin
      $display("Fail %0t: %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_kind(input string name, input log_kind_t got, input log_kind_t exp);
    check_count++;
    if (got !== exp) begin
      $display("Fail %0t: %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_src(input string name, input src_id_t got, input src_id_t exp);
    check_count++;
    if (got !== exp) begin
      $display("Fail %0t: %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      $display("Fail %0t: %s got %b expected %b", $time, name, got, exp);
      error_count++;
    end
  endtask

  // percent roll from 0 to 99
  function automatic int roll_percent();
    return $unsigned($random(seed)) % 100;
  endfunction

  // offer words one at a time and expect each begin record at offer
  task automatic drive_channel(input int ch, input int words, input data_t first);
    data_t word;
    int    k;
    for (k = 0; k < words; k++) begin
      word = first + data_t'(k);
      @(negedge clk);
      in_valid[ch] = 1'b1;
      in_data[ch]  = word;
      exp_out[ch].push_back(word);
      exp_log[ch].push_back({KIND_BEGIN, word});
      do begin
        @(posedge clk);
      end while (!in_ready[ch]);
    end
    @(negedge clk);
    in_valid[ch] = 1'b0;
  endtask

  // wait for 50 quiet cycles in a row
  task automatic drain_idle();
    int idle;
    idle = 0;
    while (idle < 50) begin
      @(posedge clk);
      if (in_valid == 2'b00 && out_valid == 2'b00 && !log_valid) begin
        idle++;
      end else begin
        idle = 0;
      end
    end
  endtask

  ////////////////////
  // ready patterns

  always @(negedge clk) begin
    if (!rstn) begin
      out_ready[0] = (roll_percent() >= out_stall_pct);
      out_ready[1] = (roll_percent() >= out_stall_pct);
      log_ready    = (roll_percent() >= log_stall_pct);
    end
  end

  ////////////////////
  // monitors

  // channel outputs and end records with the seen stall count
  always @(posedge clk) begin
    if (!rstn) begin
      for (int ch = 0; ch < 2; ch++) begin
        if (out_valid[ch] && !out_ready[ch]) begin
          stall_cnt[ch] = stall_cnt[ch] + data_t'(1);
        end
        if (out_valid[ch] && out_ready[ch]) begin
          if (exp_out[ch].size() == 0) begin
            $display("channel %0d put out word %h that was never offered", ch, out_data[ch]);
            error_count++;
          end else begin
            check_data($sformatf("ch_%0d_out_data", ch), out_data[ch], exp_out[ch].pop_front());
          end
          exp_log[ch].push_back({KIND_END, stall_cnt[ch]});
          stall_cnt[ch] = '0;
        end
      end
    end
  end

  // log bus order per source and hold while stalled
  always @(posedge clk) begin
    log_payload_t rec;
    if (!rstn) begin
      if (held_valid) begin
        check_flag("log_valid", log_valid, 1'b1);
        check_src("log_src", log_src, held_src);
        check_kind("log_kind", log_kind, held_kind);
        check_data("log_data", log_data, held_data);
      end
      held_valid = log_valid && !log_ready;
      held_src   = log_src;
      held_kind  = log_kind;
      held_data  = log_data;
      if (log_valid && log_ready) begin
        rec_count[log_src]++;
        if (exp_log[log_src].size() == 0) begin
          $display("source %0d logged a record that was not expected", log_src);
          error_count++;
        end else begin
          rec = exp_log[log_src].pop_front();
          check_kind("log_kind", log_kind, rec[DATA_W]);
          check_data("log_data", log_data, rec[DATA_W-1:0]);
        end
      end
    end
  end

  ////////////////////
  // watchdog

  initial begin
    int limit;
    limit = 1000;
    // 40 cycles budget per word
    for (int r = 0; r < $size(test_table); r++) begin
      limit += int'(test_table[r].words) * 40;
    end
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  ////////////////////
  // main sequence

  initial begin
    int errs_before;
    int nwords;
    in_valid      = 2'b00;
    in_data[0]    = '0;
    in_data[1]    = '0;
    out_ready     = 2'b00;
    log_ready     = 1'b0;
    out_stall_pct = 0;
    log_stall_pct = 0;
    stall_cnt[0]  = '0;
    stall_cnt[1]  = '0;
    held_valid    = 1'b0;
    error_count   = 0;
    check_count   = 0;

    wait (rstn === 1'b0);
    @(posedge clk);
    // everything quiet straight after reset
    check_flag("log_valid", log_valid, 1'b0);
    check_flag("ch_0_out_valid", out_valid[0], 1'b0);
    check_flag("ch_1_out_valid", out_valid[1], 1'b0);
    check_flag("ch_0_in_ready", in_ready[0], 1'b0);
    check_flag("ch_1_in_ready", in_ready[1], 1'b0);
    $display("reset check done, %0d errors", error_count);

    for (int r = 0; r < $size(test_table); r++) begin
      errs_before   = error_count;
      rec_count[0]  = 0;
      rec_count[1]  = 0;
      nwords        = int'(test_table[r].words);
      out_stall_pct = int'(test_table[r].out_stall);
      log_stall_pct = int'(test_table[r].log_stall);
      fork
        begin
          if (test_table[r].active[0]) begin
            drive_channel(0, nwords, test_table[r].first);
          end
        end
        begin
          if (test_table[r].active[1]) begin
            drive_channel(1, nwords, test_table[r].first ^ 32'h5A5A_0000);
          end
        end
      join
      drain_idle();

      for (int ch = 0; ch < 2; ch++) begin
        if (exp_out[ch].size() != 0) begin
          $display("channel %0d still owes %0d output words", ch, exp_out[ch].size());
          error_count++;
          exp_out[ch].delete();
        end
        if (exp_log[ch].size() != 0) begin
          $display("source %0d still owes %0d log records", ch, exp_log[ch].size());
          error_count++;
          exp_log[ch].delete();
        end
      end
      if (test_table[r].active == 2'b11 && (rec_count[0] == 0 || rec_count[1] == 0)) begin
        $display("both channels active but only one source reached the log bus");
        error_count++;
      end
      $display("test %0d done: channels %b, %0d words, %0d records, %0d errors", r,
               test_table[r].active, nwords, rec_count[0] + rec_count[1],
               error_count - errs_before);
    end

    $display("%0d tests, %0d checks, %0d errors", $size(test_table), check_count, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
rtl/chanlog_pkg.sv
rtl/skid_stage.sv
rtl/skid_pipeline.sv
rtl/handshake_logger.sv
rtl/log_arbiter.sv
rtl/chanlog_top.sv
tests/tb_clock.sv
tests/tb_chanlog.sv

/* run.sh */
#!/usr/bin/env bash
# build the chanlog testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_chanlog \
  -Mdir obj_dir -o sim_chanlog || { echo "build failed"; exit 1; }

out=$(./obj_dir/sim_chanlog)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1
